// File: dv/glb_strm_tb.sv
module glb_strm_tb;
    import glb_strm_pkg::*;

    localparam int LATENCY  = 9;
    localparam int WAIT_MAX = 200;

    logic      clk;
    logic      reset;
    axil_req_t axil_req;
    axil_rsp_t axil_rsp;
    packet_t   strm_in;
    packet_t   strm_out;

    // reference bank contents and which words were written
    logic [DATA_WIDTH-1:0] ref_mem  [NUM_TILES][2**BANK_ADDR_WIDTH];
    logic                  ref_known[NUM_TILES][2**BANK_ADDR_WIDTH];

    // expected packets in return order
    // injection cycle of -1 skips the latency check
    packet_t exp_q[$];
    int      inj_q[$];

    int    cycle      = 0;
    int    returned   = 0;
    logic  pipe_moved = 1'b0;
    bit    timed;
    string test_name;

    glb_strm_top uut (
        .clk      (clk),
        .reset    (reset),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp),
        .strm_in  (strm_in),
        .strm_out (strm_out)
    );

    always #20 clk = ~clk;

    // cycle count and whether the last edge moved the pipeline
    always @(posedge clk) begin
        cycle      <= cycle + 1;
        pipe_moved <= uut.clk_en;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_packet(input string name, input packet_t exp_pkt,
                                input packet_t act_pkt);
        if (act_pkt !== exp_pkt) begin
            abort_run($sformatf("mismatch %s expected %h actual %h", name, exp_pkt, act_pkt));
        end
    endtask

    task automatic check_reg(input string name, input logic [AXIL_DATA_WIDTH-1:0] exp_val,
                             input logic [AXIL_DATA_WIDTH-1:0] act_val);
        if (act_val !== exp_val) begin
            abort_run($sformatf("mismatch %s expected %h actual %h", name, exp_val, act_val));
        end
    endtask

    // returned packet is always served
    // reads carry the bank word
    function automatic packet_t expected_packet(input packet_t pkt);
        packet_t res;
        res        = pkt;
        res.served = 1'b1;
        if (pkt.op == OP_RD) begin
            res.data = ref_mem[pkt.tile_id][pkt.bank_addr];
        end
        return res;
    endfunction

    // monitor on strm_out
    // one new packet per enabled edge
    always @(negedge clk) begin
        packet_t exp_pkt;
        int      inj;
        if (!reset && pipe_moved && strm_out.valid) begin
            if (exp_q.size() == 0) begin
                abort_run("a packet came back on strm_out that was never expected");
            end else begin
                exp_pkt = exp_q.pop_front();
                inj     = inj_q.pop_front();
                check_packet(test_name, exp_pkt, strm_out);
                if (inj >= 0 && cycle - inj != LATENCY) begin
                    abort_run($sformatf("mismatch %s latency expected %0d actual %0d",
                                        test_name, LATENCY, cycle - inj));
                end
                returned++;
            end
        end
    end

    task automatic axil_write(input logic [AXIL_ADDR_WIDTH-1:0] addr,
                              input logic [AXIL_DATA_WIDTH-1:0] data, output logic [1:0] resp);
        int waited;
        @(negedge clk);
        axil_req.awvalid = 1'b1;
        axil_req.awaddr  = addr;
        axil_req.wvalid  = 1'b1;
        axil_req.wdata   = data;
        axil_req.wstrb   = '1;
        waited = 0;
        @(negedge clk);
        while (!(axil_rsp.awready && axil_rsp.wready)) begin
            waited++;
            if (waited > WAIT_MAX) abort_run("timeout waiting for awready and wready");
            @(negedge clk);
        end
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        axil_req.bready  = 1'b1;
        waited = 0;
        @(negedge clk);
        while (!axil_rsp.bvalid) begin
            waited++;
            if (waited > WAIT_MAX) abort_run("timeout waiting for the write response");
            @(negedge clk);
        end
        resp = axil_rsp.bresp;
        // response taken on the next rising edge
        @(negedge clk);
        axil_req.bready = 1'b0;
    endtask

    task automatic axil_read(input logic [AXIL_ADDR_WIDTH-1:0] addr,
                             output logic [AXIL_DATA_WIDTH-1:0] data, output logic [1:0] resp);
        int waited;
        @(negedge clk);
        axil_req.arvalid = 1'b1;
        axil_req.araddr  = addr;
        waited = 0;
        @(negedge clk);
        while (!axil_rsp.arready) begin
            waited++;
            if (waited > WAIT_MAX) abort_run("timeout waiting for arready");
            @(negedge clk);
        end
        axil_req.arvalid = 1'b0;
        axil_req.rready  = 1'b1;
        waited = 0;
        @(negedge clk);
        while (!axil_rsp.rvalid) begin
            waited++;
            if (waited > WAIT_MAX) abort_run("timeout waiting for the read data");
            @(negedge clk);
        end
        data = axil_rsp.rdata;
        resp = axil_rsp.rresp;
        @(negedge clk);
        axil_req.rready = 1'b0;
    endtask

    task automatic write_expect(input string name, input logic [AXIL_ADDR_WIDTH-1:0] addr,
                                input logic [AXIL_DATA_WIDTH-1:0] data);
        logic [1:0] resp;
        axil_write(addr, data, resp);
        check_reg({name, " bresp"}, AXIL_DATA_WIDTH'(AXIL_RESP_OKAY), AXIL_DATA_WIDTH'(resp));
    endtask

    task automatic read_expect(input string name, input logic [AXIL_ADDR_WIDTH-1:0] addr,
                               input logic [AXIL_DATA_WIDTH-1:0] exp_val);
        logic [AXIL_DATA_WIDTH-1:0] rdata;
        logic [1:0]                 resp;
        axil_read(addr, rdata, resp);
        check_reg(name, exp_val, rdata);
        check_reg({name, " rresp"}, AXIL_DATA_WIDTH'(AXIL_RESP_OKAY), AXIL_DATA_WIDTH'(resp));
    endtask

    // drive one packet
    // tracked ones go into the reference model
    task automatic send_packet(input glb_op_e op, input logic [TILE_ID_WIDTH-1:0] tile,
                               input logic [BANK_ADDR_WIDTH-1:0] addr,
                               input logic [DATA_WIDTH-1:0] data, input bit tracked);
        packet_t pkt;
        pkt           = '0;
        pkt.valid     = 1'b1;
        pkt.op        = op;
        pkt.tile_id   = tile;
        pkt.bank_addr = addr;
        pkt.data      = data;
        @(negedge clk);
        strm_in = pkt;
        if (tracked) begin
            exp_q.push_back(expected_packet(pkt));
            inj_q.push_back(timed ? cycle : -1);
            if (op == OP_WR) begin
                ref_mem[tile][addr]   = data;
                ref_known[tile][addr] = 1'b1;
            end
        end
    endtask

    // reads only where the word is already known
    task automatic send_random(input bit tracked);
        logic [TILE_ID_WIDTH-1:0]   tile;
        logic [BANK_ADDR_WIDTH-1:0] addr;
        glb_op_e                    op;
        tile = TILE_ID_WIDTH'($urandom_range(0, NUM_TILES - 1));
        addr = BANK_ADDR_WIDTH'($urandom_range(0, 2**BANK_ADDR_WIDTH - 1));
        op   = ($urandom_range(0, 1) == 1 && ref_known[tile][addr]) ? OP_RD : OP_WR;
        send_packet(op, tile, addr, DATA_WIDTH'($urandom), tracked);
    endtask

    task automatic idle_stream(input int n);
        repeat (n) begin
            @(negedge clk);
            strm_in = '0;
        end
    endtask

    task automatic drain_stream();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            waited++;
            if (waited > WAIT_MAX) abort_run("timeout, expected packets never came back");
            @(negedge clk);
        end
    endtask

    initial begin
        logic [AXIL_DATA_WIDTH-1:0] rdata;
        logic [1:0]                 resp;
        void'($urandom(36062));
        clk       = 1'b0;
        reset     = 1'b1;
        axil_req  = '0;
        strm_in   = '0;
        timed     = 1'b1;
        test_name = "reset";
        foreach (ref_known[t, a]) begin
            ref_known[t][a] = 1'b0;
        end
        repeat (2) @(negedge clk);
        reset = 1'b0;

        // frozen pipeline returns nothing
        repeat (12) begin
            send_random(1'b0);
            if (strm_out.valid) abort_run("strm_out went valid while the pipeline was disabled");
        end
        idle_stream(1);
        read_expect("reset ctrl", REG_CTRL, 0);
        read_expect("reset tile_conn", REG_TILE_CONN, 0);
        read_expect("reset pkt_count", REG_PKT_COUNT, 0);

        // tile 0 on both sides and tile 1 west only
        test_name = "config";
        write_expect("config tile_conn", REG_TILE_CONN, 32'h7);
        read_expect("config tile_conn", REG_TILE_CONN, 32'h7);
        write_expect("config ctrl", REG_CTRL, 32'h1);
        read_expect("config ctrl", REG_CTRL, 32'h1);
        write_expect("config pkt_count write", REG_PKT_COUNT, 32'h5);
        read_expect("config pkt_count", REG_PKT_COUNT, 0);

        test_name = "basic";
        for (int t = 0; t < NUM_TILES; t++) begin
            send_packet(OP_WR, TILE_ID_WIDTH'(t), BANK_ADDR_WIDTH'(5 * t + 3),
                        DATA_WIDTH'($urandom), 1'b1);
            send_packet(OP_RD, TILE_ID_WIDTH'(t), BANK_ADDR_WIDTH'(5 * t + 3), '0, 1'b1);
        end
        idle_stream(1);
        drain_stream();

        // back to back with random gaps
        test_name = "random";
        repeat (80) begin
            send_random(1'b1);
            if ($urandom_range(0, 3) == 0) idle_stream($urandom_range(1, 3));
        end
        idle_stream(1);
        drain_stream();

        // freeze with packets in flight
        test_name = "stall";
        timed     = 1'b0;
        repeat (8) send_random(1'b1);
        idle_stream(1);
        write_expect("stall disable", REG_CTRL, 32'h0);
        repeat (6) send_random(1'b0);
        idle_stream(1);
        write_expect("stall enable", REG_CTRL, 32'h1);
        repeat (8) send_random(1'b1);
        idle_stream(1);
        drain_stream();

        test_name = "count";
        idle_stream(2);
        read_expect("count pkt_count", REG_PKT_COUNT, AXIL_DATA_WIDTH'(returned));
        axil_read(4'hC, rdata, resp);
        check_reg("unmapped rresp", AXIL_DATA_WIDTH'(AXIL_RESP_SLVERR), AXIL_DATA_WIDTH'(resp));

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# build the fabric and testbench with Verilator, then run
# exit status is nonzero when the build or the simulation fails
verilator --binary --timing -Wno-fatal --top-module glb_strm_tb \
    -f verilog.f -Mdir obj_dir -o glb_strm_sim \
    && ./obj_dir/glb_strm_sim \
    || { echo "glb_strm simulation failed"; exit 1; }

// File: verilog.f
verilog/glb_strm_pkg.sv
verilog/glb_cfg_ctrl.sv
verilog/glb_strm_router.sv
verilog/glb_tile_core.sv
verilog/glb_bank.sv
verilog/glb_strm_top.sv
dv/glb_strm_tb.sv

// File: verilog/glb_bank.sv
module glb_bank (
    input  logic                                   clk,
    input  logic                                   clk_en,
    input  logic [glb_strm_pkg::BANK_ADDR_WIDTH-1:0] addr,
    input  logic                                   wr_en,
    input  logic [glb_strm_pkg::DATA_WIDTH-1:0]      wr_data,
    output logic [glb_strm_pkg::DATA_WIDTH-1:0]      rd_data
);
    import glb_strm_pkg::*;

    // 64 x 16 word array
    logic [DATA_WIDTH-1:0] mem [2**BANK_ADDR_WIDTH];

    always_ff @(posedge clk) begin
        if (clk_en) begin
            if (wr_en) begin
                mem[addr] <= wr_data;
            end
            // read before write on the same address
            rd_data <= mem[addr];
        end
    end

endmodule

// File: verilog/glb_cfg_ctrl.sv
module glb_cfg_ctrl (
    input  logic                                clk,
    input  logic                                reset,
    input  glb_strm_pkg::axil_req_t             axil_req,
    output glb_strm_pkg::axil_rsp_t             axil_rsp,
    input  logic                                pkt_returned,
    output logic                                clk_en,
    output logic [2*glb_strm_pkg::NUM_TILES-1:0] tile_conn
);
    import glb_strm_pkg::*;

    axil_state_e                state;
    logic                       en_q;
    logic [AXIL_DATA_WIDTH-1:0] pkt_count;

    // read mux, sampled when the read address is accepted
    logic [AXIL_DATA_WIDTH-1:0] rd_word;
    logic [1:0]                 rd_resp;

    always_comb begin
        rd_word = '0;
        rd_resp = AXIL_RESP_OKAY;
        case (axil_req.araddr)
            REG_CTRL: begin
                rd_word[0] = en_q;
            end
            REG_TILE_CONN: begin
                rd_word[2*NUM_TILES-1:0] = tile_conn;
            end
            REG_PKT_COUNT: begin
                rd_word = pkt_count;
            end
            default: begin
                rd_resp = AXIL_RESP_SLVERR;
            end
        endcase
    end

    // one transaction at a time
    // ready pulses on acceptance, valid rises the cycle after
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= IDLE;
            axil_rsp  <= '0;
            en_q      <= 1'b0;
            tile_conn <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (axil_req.awvalid && axil_req.wvalid) begin
                        axil_rsp.awready <= 1'b1;
                        axil_rsp.wready  <= 1'b1;
                        axil_rsp.bresp   <= AXIL_RESP_OKAY;
                        case (axil_req.awaddr)
                            REG_CTRL: begin
                                if (axil_req.wstrb[0]) begin
                                    en_q <= axil_req.wdata[0];
                                end
                            end
                            REG_TILE_CONN: begin
                                if (axil_req.wstrb[0]) begin
                                    tile_conn <= axil_req.wdata[2*NUM_TILES-1:0];
                                end
                            end
                            REG_PKT_COUNT: begin
                                // read only, write dropped
                            end
                            default: begin
                                axil_rsp.bresp <= AXIL_RESP_SLVERR;
                            end
                        endcase
                        state <= WRITE_RESP;
                    end else if (axil_req.arvalid) begin
                        axil_rsp.arready <= 1'b1;
                        axil_rsp.rdata   <= rd_word;
                        axil_rsp.rresp   <= rd_resp;
                        state            <= READ_RESP;
                    end
                end
                WRITE_RESP: begin
                    if (axil_rsp.awready) begin
                        // first cycle after acceptance
                        axil_rsp.awready <= 1'b0;
                        axil_rsp.wready  <= 1'b0;
                        axil_rsp.bvalid  <= 1'b1;
                    end else if (axil_rsp.bvalid && axil_req.bready) begin
                        axil_rsp.bvalid <= 1'b0;
                        state           <= IDLE;
                    end
                end
                READ_RESP: begin
                    if (axil_rsp.arready) begin
                        axil_rsp.arready <= 1'b0;
                        axil_rsp.rvalid  <= 1'b1;
                    end else if (axil_rsp.rvalid && axil_req.rready) begin
                        axil_rsp.rvalid <= 1'b0;
                        state           <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // returned packets, only while the pipeline runs
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pkt_count <= '0;
        end else if (clk_en && pkt_returned && (pkt_count != '1)) begin
            pkt_count <= pkt_count + 1'b1;
        end
    end

    assign clk_en = en_q;

endmodule

// File: verilog/glb_strm_pkg.sv
package glb_strm_pkg;

    // fabric size
    localparam int NUM_TILES       = 2;
    localparam int TILE_ID_WIDTH   = 1;

    // bank holds 64 words of packet data width
    localparam int BANK_ADDR_WIDTH = 6;
    localparam int DATA_WIDTH      = 16;

    // configuration bus
    localparam int AXIL_ADDR_WIDTH = 4;
    localparam int AXIL_DATA_WIDTH = 32;

    // register map
    localparam logic [AXIL_ADDR_WIDTH-1:0] REG_CTRL      = 4'h0;
    localparam logic [AXIL_ADDR_WIDTH-1:0] REG_TILE_CONN = 4'h4;
    localparam logic [AXIL_ADDR_WIDTH-1:0] REG_PKT_COUNT = 4'h8;

    // AXI response codes
    localparam logic [1:0] AXIL_RESP_OKAY   = 2'b00;
    localparam logic [1:0] AXIL_RESP_SLVERR = 2'b10;

    typedef enum logic {
        OP_WR = 1'b0,
        OP_RD = 1'b1
    } glb_op_e;

    // 26-bit stream packet
    typedef struct packed {
        logic                       valid;
        glb_op_e                    op;
        logic [TILE_ID_WIDTH-1:0]   tile_id;
        logic [BANK_ADDR_WIDTH-1:0] bank_addr;
        logic [DATA_WIDTH-1:0]      data;
        logic                       served;
    } packet_t;

    typedef struct packed {
        logic                         awvalid;
        logic [AXIL_ADDR_WIDTH-1:0]   awaddr;
        logic                         wvalid;
        logic [AXIL_DATA_WIDTH-1:0]   wdata;
        logic [AXIL_DATA_WIDTH/8-1:0] wstrb;
        logic                         bready;
        logic                         arvalid;
        logic [AXIL_ADDR_WIDTH-1:0]   araddr;
        logic                         rready;
    } axil_req_t;

    typedef struct packed {
        logic                       awready;
        logic                       wready;
        logic                       bvalid;
        logic [1:0]                 bresp;
        logic                       arready;
        logic                       rvalid;
        logic [AXIL_DATA_WIDTH-1:0] rdata;
        logic [1:0]                 rresp;
    } axil_rsp_t;

    typedef enum logic [1:0] {
        IDLE       = 2'd0,
        WRITE_RESP = 2'd1,
        READ_RESP  = 2'd2
    } axil_state_e;

endpackage

// File: verilog/glb_strm_router.sv
module glb_strm_router #(
    parameter logic [glb_strm_pkg::TILE_ID_WIDTH-1:0] TILE_ID = '0
) (
    input  logic                  clk,
    input  logic                  clk_en,
    input  logic                  reset,
    input  glb_strm_pkg::packet_t w2e_wsti,
    output glb_strm_pkg::packet_t e2w_wsto,
    input  glb_strm_pkg::packet_t e2w_esti,
    output glb_strm_pkg::packet_t w2e_esto,
    output glb_strm_pkg::packet_t to_core,
    input  glb_strm_pkg::packet_t from_core,
    input  logic                  connected_prev,
    input  logic                  connected_next
);
    import glb_strm_pkg::*;

    packet_t w2e_wsti_q;
    packet_t e2w_esti_q;
    packet_t w2e_turned;
    packet_t e2w_turned;
    packet_t w2e_esto_d;
    packet_t e2w_wsto_d;
    packet_t w2e_esto_q;
    packet_t e2w_wsto_q;
    logic    is_even;

    // tile 0 counts as even
    assign is_even = (TILE_ID[0] == 1'b0);

    // neighbor input registers
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            w2e_wsti_q <= '0;
            e2w_esti_q <= '0;
        end else if (clk_en) begin
            w2e_wsti_q <= w2e_wsti;
            e2w_esti_q <= e2w_esti;
        end
    end

    // open edge loops the outgoing register back in
    assign w2e_turned = connected_prev ? w2e_wsti_q : e2w_wsto_q;
    assign e2w_turned = connected_next ? e2w_esti_q : w2e_esto_q;

    // even tile serves eastbound, odd tile serves westbound
    assign to_core    = is_even ? w2e_turned : e2w_turned;
    assign w2e_esto_d = is_even ? from_core  : w2e_turned;
    assign e2w_wsto_d = is_even ? e2w_turned : from_core;

    // output registers toward the neighbors
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            w2e_esto_q <= '0;
            e2w_wsto_q <= '0;
        end else if (clk_en) begin
            w2e_esto_q <= w2e_esto_d;
            e2w_wsto_q <= e2w_wsto_d;
        end
    end

    assign w2e_esto = w2e_esto_q;
    assign e2w_wsto = e2w_wsto_q;

endmodule

// File: verilog/glb_strm_top.sv
module glb_strm_top (
    input  logic                    clk,
    input  logic                    reset,
    input  glb_strm_pkg::axil_req_t axil_req,
    output glb_strm_pkg::axil_rsp_t axil_rsp,
    input  glb_strm_pkg::packet_t   strm_in,
    output glb_strm_pkg::packet_t   strm_out
);
    import glb_strm_pkg::*;

    logic                   clk_en;
    logic [2*NUM_TILES-1:0] tile_conn;

    // per-tile stream hops
    packet_t w2e_in   [NUM_TILES];
    packet_t w2e_out  [NUM_TILES];
    packet_t e2w_in   [NUM_TILES];
    packet_t e2w_out  [NUM_TILES];
    packet_t to_core  [NUM_TILES];
    packet_t from_core[NUM_TILES];

    // core to bank
    logic [BANK_ADDR_WIDTH-1:0] bank_addr   [NUM_TILES];
    logic                       bank_wr_en  [NUM_TILES];
    logic [DATA_WIDTH-1:0]      bank_wr_data[NUM_TILES];
    logic [DATA_WIDTH-1:0]      bank_rd_data[NUM_TILES];

    glb_cfg_ctrl u_cfg (
        .clk          (clk),
        .reset        (reset),
        .axil_req     (axil_req),
        .axil_rsp     (axil_rsp),
        .pkt_returned (strm_out.valid),
        .clk_en       (clk_en),
        .tile_conn    (tile_conn)
    );

    // returning packets leave on the west edge of tile 0
    assign strm_out = e2w_out[0];

    for (genvar i = 0; i < NUM_TILES; i++) begin : g_tile
        // west neighbor or host
        if (i == 0) begin : g_west_edge
            assign w2e_in[i] = strm_in;
        end else begin : g_west_link
            assign w2e_in[i] = w2e_out[i-1];
        end

        // east neighbor, last tile has none
        if (i == NUM_TILES - 1) begin : g_east_edge
            assign e2w_in[i] = '0;
        end else begin : g_east_link
            assign e2w_in[i] = e2w_out[i+1];
        end

        glb_strm_router #(
            .TILE_ID (TILE_ID_WIDTH'(i))
        ) u_router (
            .clk            (clk),
            .clk_en         (clk_en),
            .reset          (reset),
            .w2e_wsti       (w2e_in[i]),
            .e2w_wsto       (e2w_out[i]),
            .e2w_esti       (e2w_in[i]),
            .w2e_esto       (w2e_out[i]),
            .to_core        (to_core[i]),
            .from_core      (from_core[i]),
            .connected_prev (tile_conn[2*i]),
            .connected_next (tile_conn[2*i+1])
        );

        glb_tile_core #(
            .TILE_ID (TILE_ID_WIDTH'(i))
        ) u_core (
            .clk          (clk),
            .clk_en       (clk_en),
            .reset        (reset),
            .pkt_in       (to_core[i]),
            .pkt_out      (from_core[i]),
            .bank_addr    (bank_addr[i]),
            .bank_wr_en   (bank_wr_en[i]),
            .bank_wr_data (bank_wr_data[i]),
            .bank_rd_data (bank_rd_data[i])
        );

        glb_bank u_bank (
            .clk     (clk),
            .clk_en  (clk_en),
            .addr    (bank_addr[i]),
            .wr_en   (bank_wr_en[i]),
            .wr_data (bank_wr_data[i]),
            .rd_data (bank_rd_data[i])
        );
    end

endmodule

// File: verilog/glb_tile_core.sv
module glb_tile_core #(
    parameter logic [glb_strm_pkg::TILE_ID_WIDTH-1:0] TILE_ID = '0
) (
    input  logic                                   clk,
    input  logic                                   clk_en,
    input  logic                                   reset,
    input  glb_strm_pkg::packet_t                  pkt_in,
    output glb_strm_pkg::packet_t                  pkt_out,
    output logic [glb_strm_pkg::BANK_ADDR_WIDTH-1:0] bank_addr,
    output logic                                   bank_wr_en,
    output logic [glb_strm_pkg::DATA_WIDTH-1:0]      bank_wr_data,
    input  logic [glb_strm_pkg::DATA_WIDTH-1:0]      bank_rd_data
);
    import glb_strm_pkg::*;

    logic    tile_hit;
    logic    rd_hit;
    packet_t pkt_q;
    logic    rd_hit_q;

    // packet addressed to this tile
    assign tile_hit = pkt_in.valid && (pkt_in.tile_id == TILE_ID);
    assign rd_hit   = tile_hit && (pkt_in.op == OP_RD);

    // bank side driven straight from the incoming packet
    assign bank_addr    = pkt_in.bank_addr;
    assign bank_wr_en   = tile_hit && (pkt_in.op == OP_WR);
    assign bank_wr_data = pkt_in.data;

    // one stage, lines up with the bank read latency
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pkt_q    <= '0;
            rd_hit_q <= 1'b0;
        end else if (clk_en) begin
            pkt_q <= pkt_in;
            if (tile_hit) begin
                pkt_q.served <= 1'b1;
            end
            rd_hit_q <= rd_hit;
        end
    end

    // read data comes from the bank output register
    always_comb begin
        pkt_out = pkt_q;
        if (rd_hit_q) begin
            pkt_out.data = bank_rd_data;
        end
    end

endmodule
